/* verilog.f */
logic/core_pkg.sv
logic/instr_queue.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/retire_tracker.sv
logic/core_top.sv
test/core_properties.sv
test/core_tb.sv

/* test/core_tb.sv */
// Core testbench with stimulus table, reference model, trace checks and timeout
`timescale 1ns/100ps

module core_tb;
    import core_pkg::*;

    localparam int N_INSTR     = 24;
    localparam int CYCLE_LIMIT = N_INSTR * 12 + 100;

    logic                  clk;
    logic                  rst;
    logic                  instr_valid;
    logic [WORD_W-1:0]     instr_word;
    logic                  trace_credit;
    logic                  instr_credit;
    logic                  trace_valid;
    logic [SEQ_W-1:0]      trace_seq;
    logic [REG_ADDR_W-1:0] trace_rd;
    logic [WORD_W-1:0]     trace_value;
    logic                  trace_write;
    logic [CYCLE_W-1:0]    trace_issue_cycle;
    logic [CYCLE_W-1:0]    trace_retire_cycle;

    // A zero gap in the stimulus table means a random credit delay
    instr_word_u       prog_word  [N_INSTR];
    int                prog_gap   [N_INSTR];
    int                rand_delay [N_INSTR];
    int                issue_at   [N_INSTR];
    logic [WORD_W-1:0] model_regs [REG_COUNT];
    int                credit_due [$];

    int cycle_now;
    int sent_count;
    int credit_pulses;
    int retired;
    int returns;
    int last_zero;
    int late_retires;
    int value_errors;
    int protocol_errors;
    int watchdog_cycles;

    core_top dut0 (.*);

    bind core_top core_properties props0 (
        .clk                (clk),
        .rst                (rst),
        .instr_valid        (instr_valid),
        .instr_credit       (instr_credit),
        .trace_valid        (trace_valid),
        .trace_credit       (trace_credit),
        .trace_issue_cycle  (trace_issue_cycle),
        .trace_retire_cycle (trace_retire_cycle)
    );

    function automatic instr_word_u reg_form(input opcode_e op, input int rd, input int rs1,
                                             input int rs2);
        instr_word_u w;
        w.r.opcode = op;
        w.r.rd     = REG_ADDR_W'(rd);
        w.r.rs1    = REG_ADDR_W'(rs1);
        w.r.rs2    = REG_ADDR_W'(rs2);
        w.r.unused = '0;
        return w;
    endfunction

    function automatic instr_word_u imm_form(input opcode_e op, input int rd, input int rs1,
                                             input int imm);
        instr_word_u w;
        w.i.opcode = op;
        w.i.rd     = REG_ADDR_W'(rd);
        w.i.rs1    = REG_ADDR_W'(rs1);
        w.i.imm    = IMM_W'(imm);
        return w;
    endfunction

    task automatic set_row(input int k, input instr_word_u w, input int gap);
        prog_word[k] = w;
        prog_gap[k]  = gap;
    endtask

    ////////////////////
    // Program with dependent chains and two forced credit gaps
    task automatic load_table();
        set_row(0,  imm_form(OP_ADDI, 1, 0, 5), 0);
        set_row(1,  imm_form(OP_ADDI, 2, 0, -3), 0);
        set_row(2,  reg_form(OP_ADD, 3, 1, 2), 0);
        set_row(3,  reg_form(OP_SUB, 4, 3, 1), 0);
        set_row(4,  reg_form(OP_AND, 5, 4, 2), 24);
        set_row(5,  reg_form(OP_OR, 6, 5, 1), 0);
        set_row(6,  reg_form(OP_XOR, 7, 6, 4), 0);
        set_row(7,  imm_form(OP_SHLI, 1, 1, 4), 0);
        set_row(8,  imm_form(OP_SHLI, 2, 2, 15), 0);
        set_row(9,  reg_form(OP_ADD, 3, 2, 2), 0);
        set_row(10, reg_form(OP_NOP, 5, 1, 1), 0);
        set_row(11, imm_form(OP_ADDI, 4, 4, 31), 0);
        set_row(12, imm_form(OP_ADDI, 5, 4, -32), 0);
        set_row(13, 16'h9E4B, 0);
        set_row(14, imm_form(OP_SHLI, 6, 1, -1), 0);
        set_row(15, reg_form(OP_SUB, 7, 0, 1), 20);
        set_row(16, reg_form(OP_ADD, 1, 7, 6), 0);
        set_row(17, reg_form(OP_XOR, 2, 1, 1), 0);
        set_row(18, imm_form(OP_ADDI, 2, 2, -1), 0);
        set_row(19, reg_form(OP_OR, 3, 2, 7), 0);
        set_row(20, reg_form(OP_AND, 4, 3, 6), 0);
        set_row(21, reg_form(OP_SUB, 5, 4, 2), 0);
        set_row(22, imm_form(OP_ADDI, 6, 5, 1), 0);
        set_row(23, reg_form(OP_ADD, 7, 6, 6), 0);
    endtask

    // Architectural result of one instruction against the model registers
    task automatic predict(input instr_word_u w, output logic wr,
                           output logic [REG_ADDR_W-1:0] rd, output logic [WORD_W-1:0] value);
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        int                imm_val;
        a       = model_regs[w.r.rs1];
        b       = model_regs[w.r.rs2];
        imm_val = $signed(w.i.imm);
        wr      = 1'b1;
        rd      = w.r.rd;
        case (w.r.opcode)
            OP_ADD:  value = a + b;
            OP_SUB:  value = a - b;
            OP_AND:  value = a & b;
            OP_OR:   value = a | b;
            OP_XOR:  value = a ^ b;
            OP_ADDI: value = a + WORD_W'(imm_val);
            OP_SHLI: value = a << (imm_val & 15);
            default: begin
                value = '0;
                wr    = 1'b0;
            end
        endcase
    endtask

    task automatic expect_equal(input string name, input logic [WORD_W-1:0] got,
                                input logic [WORD_W-1:0] expected);
        assert (got === expected) else begin
            value_errors++;
            $display("FAILED %s: got %h expected %h at seq %0d", name, got, expected, retired);
        end
    endtask

    task automatic check_retire();
        logic                  exp_write;
        logic [REG_ADDR_W-1:0] exp_rd;
        logic [WORD_W-1:0]     exp_value;
        int                    k;
        k = retired;
        assert (k < sent_count) else begin
            protocol_errors++;
            $display("Trace record arrived with no instruction outstanding at cycle %0d", cycle_now);
        end
        if (k < sent_count) begin
            predict(prog_word[k], exp_write, exp_rd, exp_value);
            expect_equal("trace_seq", trace_seq, WORD_W'(k % 256));
            expect_equal("trace_write", trace_write, exp_write);
            expect_equal("trace_value", trace_value, exp_value);
            if (exp_write) begin
                expect_equal("trace_rd", trace_rd, exp_rd);
                model_regs[exp_rd] = exp_value;
            end
            expect_equal("trace_issue_cycle", trace_issue_cycle, issue_at[k]);
            expect_equal("trace_retire_cycle", trace_retire_cycle, cycle_now);
            // Exactly two cycles unless credits ran dry since issue
            if (last_zero < issue_at[k]) begin
                expect_equal("trace_retire_cycle", trace_retire_cycle, issue_at[k] + 2);
            end else begin
                assert (cycle_now >= issue_at[k] + 2) else begin
                    protocol_errors++;
                    $display("Instruction %0d retired under two cycles after issue", k);
                end
                if (cycle_now > issue_at[k] + 2) begin
                    late_retires++;
                end
            end
            credit_due.push_back(cycle_now + ((prog_gap[k] != 0) ? prog_gap[k] : rand_delay[k]));
            retired++;
        end
    endtask

    task automatic report_counts();
        $display("Summary: %0d of %0d retired, %0d value, %0d protocol, %0d assertion errors",
                 retired, N_INSTR, value_errors, protocol_errors, dut0.props0.failure_count);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Mirror of the core's free cycle counter
    always @(posedge clk) begin
        if (rst) begin
            cycle_now <= 0;
        end else begin
            cycle_now <= cycle_now + 1;
        end
    end

    // Trace credits go back in retire order once due
    always @(posedge clk) begin
        if (!rst && credit_due.size() > 0 && credit_due[0] <= cycle_now) begin
            trace_credit <= 1'b1;
            void'(credit_due.pop_front());
        end else begin
            trace_credit <= 1'b0;
        end
    end

    ////////////////////
    // Monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (TRACE_CREDITS - retired + returns == 0) begin
                last_zero = cycle_now;
            end
            if (instr_credit) begin
                if (credit_pulses < N_INSTR) begin
                    issue_at[credit_pulses] = cycle_now;
                end
                credit_pulses++;
            end
            if (trace_valid) begin
                check_retire();
            end
            if (trace_credit) begin
                returns++;
            end
        end
    end

    initial begin
        rst             = 1'b1;
        instr_valid     = 1'b0;
        instr_word      = '0;
        trace_credit    = 1'b0;
        sent_count      = 0;
        credit_pulses   = 0;
        retired         = 0;
        returns         = 0;
        last_zero       = -1;
        late_retires    = 0;
        value_errors    = 0;
        protocol_errors = 0;
        void'($urandom(95));
        for (int k = 0; k < N_INSTR; k++) begin
            rand_delay[k] = 1 + int'($urandom % 3);
        end
        for (int r = 0; r < REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        load_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // Host sends only while it holds an instruction credit
        for (int k = 0; k < N_INSTR; k++) begin
            while (QUEUE_DEPTH - sent_count + credit_pulses == 0) begin
                instr_valid <= 1'b0;
                @(posedge clk);
            end
            instr_valid <= 1'b1;
            instr_word  <= prog_word[k];
            sent_count++;
            @(posedge clk);
        end
        instr_valid <= 1'b0;
        while (retired < N_INSTR || returns < N_INSTR) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        expect_equal("instr_credit", WORD_W'(credit_pulses), WORD_W'(N_INSTR));
        assert (QUEUE_DEPTH - sent_count + credit_pulses == QUEUE_DEPTH) else begin
            protocol_errors++;
            $display("Host did not get all its instruction credits back");
        end
        assert (late_retires > 0) else begin
            protocol_errors++;
            $display("No retirement was delayed by trace credit starvation");
        end
        report_counts();
        if (value_errors + protocol_errors + dut0.props0.failure_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        watchdog_cycles = 0;
        while (watchdog_cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            watchdog_cycles++;
        end
        $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                 watchdog_cycles, retired, N_INSTR);
        report_counts();
        $display("Test failed");
        $finish;
    end

endmodule

/* test/core_properties.sv */
// Bound concurrent checks on the instruction credit, trace credit and retire stamp rules
`timescale 1ns/100ps

module core_properties (
    input logic                         clk,
    input logic                         rst,
    input logic                         instr_valid,
    input logic                         instr_credit,
    input logic                         trace_valid,
    input logic                         trace_credit,
    input logic [core_pkg::CYCLE_W-1:0] trace_issue_cycle,
    input logic [core_pkg::CYCLE_W-1:0] trace_retire_cycle
);
    import core_pkg::*;

    int trace_credits;
    int queue_used;
    int failure_count = 0;

    // Credit views as seen from the ports
    always @(posedge clk) begin
        if (rst) begin
            trace_credits <= TRACE_CREDITS;
            queue_used    <= 0;
        end else begin
            trace_credits <= trace_credits - int'(trace_valid) + int'(trace_credit);
            queue_used    <= queue_used + int'(instr_valid) - int'(instr_credit);
        end
    end

    trace_needs_credit: assert property (@(posedge clk) disable iff (rst)
        trace_valid |-> (trace_credits > 0))
        else begin
            $error("trace_valid raised while no trace credit was held");
            failure_count++;
        end

    host_within_depth: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> (queue_used < QUEUE_DEPTH))
        else begin
            $error("host wrote more instructions than the queue holds");
            failure_count++;
        end

    retire_after_issue: assert property (@(posedge clk) disable iff (rst)
        trace_valid |-> (int'(trace_retire_cycle) >= int'(trace_issue_cycle) + 2))
        else begin
            $error("retire stamp is less than two cycles after the issue stamp");
            failure_count++;
        end

endmodule

/* logic/core_top.sv */
// Core top level: queue, register file, three stages and the tracker
`timescale 1ns/100ps

module core_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            instr_valid,
    input  logic [core_pkg::WORD_W-1:0]     instr_word,
    input  logic                            trace_credit,
    output logic                            instr_credit,
    output logic                            trace_valid,
    output logic [core_pkg::SEQ_W-1:0]      trace_seq,
    output logic [core_pkg::REG_ADDR_W-1:0] trace_rd,
    output logic [core_pkg::WORD_W-1:0]     trace_value,
    output logic                            trace_write,
    output logic [core_pkg::CYCLE_W-1:0]    trace_issue_cycle,
    output logic [core_pkg::CYCLE_W-1:0]    trace_retire_cycle
);
    import core_pkg::*;

    logic                  pop_valid;
    logic                  pop_ready;
    logic [WORD_W-1:0]     pop_word;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [WORD_W-1:0]     rs1_data;
    logic [WORD_W-1:0]     rs2_data;

    // Decode to execute
    logic                  dec_valid;
    opcode_e               dec_op;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [WORD_W-1:0]     dec_a;
    logic [WORD_W-1:0]     dec_b;
    logic                  dec_write;

    // Execute to result, also forwarded to decode
    logic                  ex_valid;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [WORD_W-1:0]     ex_value;
    logic                  ex_write;

    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [WORD_W-1:0]     wb_data;
    logic                  stall;
    logic [SEQ_W-1:0]      ret_seq;
    logic [CYCLE_W-1:0]    ret_issue_cycle;
    logic [CYCLE_W-1:0]    ret_cycle;

    instr_queue    queue0   (.*);
    register_file  regs0    (.*);
    decode_stage   decode0  (.*);
    execute_stage  execute0 (.*);
    result_stage   result0  (.*);
    retire_tracker tracker0 (.*);

endmodule

/* logic/retire_tracker.sv */
// Instruction tracker: cycle counter, sequence counter and per-stage stamps
`timescale 1ns/100ps

module retire_tracker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         stall,
    input  logic                         pop_valid,
    input  logic                         pop_ready,
    input  logic                         dec_valid,
    input  logic                         ex_valid,
    input  logic                         trace_valid,
    output logic [core_pkg::SEQ_W-1:0]   ret_seq,
    output logic [core_pkg::CYCLE_W-1:0] ret_issue_cycle,
    output logic [core_pkg::CYCLE_W-1:0] ret_cycle
);
    import core_pkg::*;

    logic [CYCLE_W-1:0] cycle_count;
    logic [SEQ_W-1:0]   seq_count;
    logic               issue;
    logic               r_busy;
    logic               r_advance;

    // Shadow stamps, one pair per stage
    logic [SEQ_W-1:0]   d_seq;
    logic [SEQ_W-1:0]   e_seq;
    logic [SEQ_W-1:0]   r_seq;
    logic [CYCLE_W-1:0] d_issue;
    logic [CYCLE_W-1:0] e_issue;
    logic [CYCLE_W-1:0] r_issue;

    assign issue = pop_valid && pop_ready;

    // Result slot takes a new entry when empty or retiring
    assign r_advance = !r_busy || trace_valid;

    ////////////////////
    // Counters
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_count <= '0;
            seq_count   <= '0;
            r_busy      <= 1'b0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
            if (issue) begin
                seq_count <= seq_count + 1'b1;
            end
            if (r_advance) begin
                r_busy <= ex_valid;
            end
        end
    end

    ////////////////////
    // Shadow pipeline
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (issue) begin
                d_seq   <= seq_count;
                // Stamp the first cycle spent in decode
                d_issue <= cycle_count + 1'b1;
            end
            if (dec_valid) begin
                e_seq   <= d_seq;
                e_issue <= d_issue;
            end
        end
        if (r_advance && ex_valid) begin
            r_seq   <= e_seq;
            r_issue <= e_issue;
        end
    end

    assign ret_seq         = r_seq;
    assign ret_issue_cycle = r_issue;
    assign ret_cycle       = cycle_count;

endmodule

/* logic/result_stage.sv */
// Result stage: result register, write-back, trace port and trace credits
`timescale 1ns/100ps

module result_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            trace_credit,
    input  logic                            ex_valid,
    input  logic [core_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic [core_pkg::WORD_W-1:0]     ex_value,
    input  logic                            ex_write,
    input  logic [core_pkg::SEQ_W-1:0]      ret_seq,
    input  logic [core_pkg::CYCLE_W-1:0]    ret_issue_cycle,
    input  logic [core_pkg::CYCLE_W-1:0]    ret_cycle,
    output logic                            stall,
    output logic                            wb_en,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [core_pkg::WORD_W-1:0]     wb_data,
    output logic                            trace_valid,
    output logic [core_pkg::SEQ_W-1:0]      trace_seq,
    output logic [core_pkg::REG_ADDR_W-1:0] trace_rd,
    output logic [core_pkg::WORD_W-1:0]     trace_value,
    output logic                            trace_write,
    output logic [core_pkg::CYCLE_W-1:0]    trace_issue_cycle,
    output logic [core_pkg::CYCLE_W-1:0]    trace_retire_cycle
);
    import core_pkg::*;

    logic [TRACE_CNT_W-1:0] credit_count;
    logic                   has_credit;
    logic                   res_valid;
    logic [REG_ADDR_W-1:0]  res_rd;
    logic [WORD_W-1:0]      res_value;
    logic                   res_write;

    ////////////////////
    // Retire decision
    assign has_credit  = (credit_count != '0);
    assign trace_valid = res_valid && has_credit;
    assign stall       = res_valid && !has_credit;

    assign wb_en   = trace_valid && res_write;
    assign wb_addr = res_rd;
    assign wb_data = res_value;

    assign trace_seq          = ret_seq;
    assign trace_rd           = res_rd;
    assign trace_value        = res_value;
    assign trace_write        = res_write;
    assign trace_issue_cycle  = ret_issue_cycle;
    assign trace_retire_cycle = ret_cycle;

    ////////////////////
    // Result register and credits
    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid    <= 1'b0;
            credit_count <= TRACE_CNT_W'(TRACE_CREDITS);
        end else begin
            if (!stall) begin
                res_valid <= ex_valid;
            end
            credit_count <= credit_count - TRACE_CNT_W'(trace_valid)
                            + TRACE_CNT_W'(trace_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            res_rd    <= ex_rd;
            res_value <= ex_value;
            res_write <= ex_write;
        end
    end

endmodule

/* logic/execute_stage.sv */
// Execute stage: ALU and execute register
`timescale 1ns/100ps

module execute_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            stall,
    input  logic                            dec_valid,
    input  core_pkg::opcode_e               dec_op,
    input  logic [core_pkg::REG_ADDR_W-1:0] dec_rd,
    input  logic [core_pkg::WORD_W-1:0]     dec_a,
    input  logic [core_pkg::WORD_W-1:0]     dec_b,
    input  logic                            dec_write,
    output logic                            ex_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic [core_pkg::WORD_W-1:0]     ex_value,
    output logic                            ex_write
);
    import core_pkg::*;

    logic [WORD_W-1:0] alu_value;

    // All results wrap at 16 bits
    always_comb begin
        case (dec_op)
            OP_ADD, OP_ADDI: begin
                alu_value = dec_a + dec_b;
            end
            OP_SUB: begin
                alu_value = dec_a - dec_b;
            end
            OP_AND: begin
                alu_value = dec_a & dec_b;
            end
            OP_OR: begin
                alu_value = dec_a | dec_b;
            end
            OP_XOR: begin
                alu_value = dec_a ^ dec_b;
            end
            OP_SHLI: begin
                alu_value = dec_a << dec_b[SHAMT_W-1:0];
            end
            default: begin
                alu_value = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (!stall) begin
            ex_valid <= dec_valid;
        end
    end

    // Payload freezes with the valid bit under stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_rd    <= dec_rd;
            ex_value <= alu_value;
            ex_write <= dec_write;
        end
    end

endmodule

/* logic/decode_stage.sv */
// Decode stage: field decode, decode register and operand forwarding
`timescale 1ns/100ps

module decode_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            stall,
    input  logic                            pop_valid,
    input  logic [core_pkg::WORD_W-1:0]     pop_word,
    input  logic [core_pkg::WORD_W-1:0]     rs1_data,
    input  logic [core_pkg::WORD_W-1:0]     rs2_data,
    input  logic                            ex_valid,
    input  logic                            ex_write,
    input  logic [core_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic [core_pkg::WORD_W-1:0]     ex_value,
    input  logic                            wb_en,
    input  logic [core_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [core_pkg::WORD_W-1:0]     wb_data,
    output logic                            pop_ready,
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic                            dec_valid,
    output core_pkg::opcode_e               dec_op,
    output logic [core_pkg::REG_ADDR_W-1:0] dec_rd,
    output logic [core_pkg::WORD_W-1:0]     dec_a,
    output logic [core_pkg::WORD_W-1:0]     dec_b,
    output logic                            dec_write
);
    import core_pkg::*;

    instr_word_u       word;
    opcode_e           op;
    logic              use_imm;
    logic [WORD_W-1:0] imm_ext;
    logic              d_use_imm;
    logic [WORD_W-1:0] d_imm;

    // Newest producer wins: execute, then write-back, then the file
    function automatic logic [WORD_W-1:0] operand(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [WORD_W-1:0]     rf_data
    );
        if (ex_valid && ex_write && (ex_rd == addr)) begin
            return ex_value;
        end else if (wb_en && (wb_addr == addr)) begin
            return wb_data;
        end
        return rf_data;
    endfunction

    assign pop_ready = !stall;

    ////////////////////
    // Field decode
    always_comb begin
        word = pop_word;
        op   = word.r.opcode;
        if (op > OP_SHLI) begin
            op = OP_NOP;
        end
        use_imm = (op == OP_ADDI) || (op == OP_SHLI);
        imm_ext = {{(WORD_W - IMM_W){word.i.imm[IMM_W-1]}}, word.i.imm};
    end

    ////////////////////
    // Decode register
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= pop_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dec_op    <= op;
            dec_rd    <= word.r.rd;
            rs1_addr  <= word.r.rs1;
            rs2_addr  <= word.r.rs2;
            dec_write <= (op != OP_NOP);
            d_use_imm <= use_imm;
            d_imm     <= imm_ext;
        end
    end

    // Operands are read while the instruction sits in decode
    always_comb begin
        dec_a = operand(rs1_addr, rs1_data);
        dec_b = d_use_imm ? d_imm : operand(rs2_addr, rs2_data);
    end

endmodule

/* logic/register_file.sv */
// Eight-entry register file, two combinational reads and one clocked write
`timescale 1ns/100ps

module register_file (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic                            wb_en,
    input  logic [core_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [core_pkg::WORD_W-1:0]     wb_data,
    output logic [core_pkg::WORD_W-1:0]     rs1_data,
    output logic [core_pkg::WORD_W-1:0]     rs2_data
);
    import core_pkg::*;

    logic [WORD_W-1:0] regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Same-cycle write bypass is done in decode
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

/* logic/instr_queue.sv */
// Instruction FIFO between the host and decode, with credit return on pop
`timescale 1ns/100ps

module instr_queue (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_valid,
    input  logic [core_pkg::WORD_W-1:0] instr_word,
    input  logic                        pop_ready,
    output logic                        instr_credit,
    output logic                        pop_valid,
    output logic [core_pkg::WORD_W-1:0] pop_word
);
    import core_pkg::*;

    logic [WORD_W-1:0]      entries [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   push;
    logic                   pop;

    // Writes into a full queue are dropped
    assign push = instr_valid && (count != QUEUE_CNT_W'(QUEUE_DEPTH));
    assign pop  = pop_valid && pop_ready;

    assign pop_valid = (count != '0);
    assign pop_word  = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= instr_word;
        end
    end

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            instr_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count        <= count + QUEUE_CNT_W'(push) - QUEUE_CNT_W'(pop);
            instr_credit <= pop;
        end
    end

endmodule

/* logic/core_pkg.sv */
// Core sizes, opcodes, credit depths and the instruction word views
package core_pkg;

    localparam int WORD_W     = 16;
    localparam int REG_COUNT  = 8;
    localparam int REG_ADDR_W = 3;
    localparam int SEQ_W      = 8;
    localparam int CYCLE_W    = 16;
    localparam int IMM_W      = 6;
    localparam int SHAMT_W    = $clog2(WORD_W);

    // Queue depth is also the host's starting instruction credit
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    localparam int TRACE_CREDITS = 4;
    localparam int TRACE_CNT_W   = $clog2(TRACE_CREDITS + 1);

    // Codes above OP_SHLI decode as NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_SHLI = 4'd7
    } opcode_e;

    // Register form and immediate form share opcode, rd and rs1
    typedef union packed {
        struct packed {
            opcode_e               opcode;
            logic [REG_ADDR_W-1:0] rd;
            logic [REG_ADDR_W-1:0] rs1;
            logic [REG_ADDR_W-1:0] rs2;
            logic [2:0]            unused;
        } r;
        struct packed {
            opcode_e                 opcode;
            logic [REG_ADDR_W-1:0]   rd;
            logic [REG_ADDR_W-1:0]   rs1;
            logic signed [IMM_W-1:0] imm;
        } i;
    } instr_word_u;

endpackage
